/* src/awCtrl_consts.svh */
/*
 * Widths and address map for the AW channel controller.
 * Included by the packages, the decoder and the testbench.
 */

`ifndef AW_CTRL_CONSTS_SVH
`define AW_CTRL_CONSTS_SVH

// ========================================
// AW field widths
// ========================================
`define AW_ADDR_W   32      // Write address
`define AW_LEN_W    8       // AXI4 burst length
`define AW_SIZE_W   3       // Bytes per beat code
`define AW_BURST_W  2
`define AW_QOS_W    4       // Priority

// Source id carried out as awid
`define AW_ID_W     1

// Number of write subordinates behind the switch
`define AW_NUM_TGT  2

// ========================================
// Address map
// ========================================
// M00 owns the lower half, everything else falls to M01
`define AW_M00_BASE 32'h0000_0000
`define AW_M00_MASK 32'h8000_0000

`endif

/* src/axiFieldsPkg.sv */
/*
 * Types for the AXI4 write address fields.
 * Shared by the arbiter, decoder, switch and the top level.
 */

package axiFieldsPkg;

`include "awCtrl_consts.svh"

    // ========================================
    // Plain field types
    // ========================================
    typedef logic [`AW_ADDR_W-1:0] addrT;
    typedef logic [`AW_LEN_W-1:0]  lenT;   // Beats minus one
    typedef logic [`AW_SIZE_W-1:0] sizeT;
    typedef logic [`AW_QOS_W-1:0]  qosT;   // Higher wins

    // Burst type encoding as on the bus
    typedef enum logic [`AW_BURST_W-1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burstT;

endpackage

/* src/awCtrlPkg.sv */
/*
 * Controller-side types for the AW channel.
 * Source and target ids, arbiter state and the queue enable vector.
 */

package awCtrlPkg;

`include "awCtrl_consts.svh"

    typedef enum logic [`AW_ID_W-1:0] {
        SRC_S00 = 1'b0,
        SRC_S01 = 1'b1
    } srcT;

    typedef enum logic [0:0] {
        TGT_M00 = 1'b0,     // Region match
        TGT_M01 = 1'b1      // Default subordinate
    } tgtT;

    typedef enum logic [0:0] {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arbStateT;

    // One bit per subordinate write data queue
    typedef logic [`AW_NUM_TGT-1:0] qEnT;

endpackage

/* src/qosArbiter.sv */
/*
 * Picks the next write address source by QoS.
 * Equal QoS goes to the source favored by a round-robin pointer.
 * The grant is held until the switch reports the handshake.
 */

`timescale 1ns/10ps

module qosArbiter
    import axiFieldsPkg::*;
    import awCtrlPkg::*;
(
    input  logic ACLK,
    input  logic rst,

    input  logic s00Valid,
    input  qosT  s00Qos,
    input  logic s01Valid,
    input  qosT  s01Qos,

    input  logic xferDone,      // Handshake seen by the switch
    output logic grantValid,
    output srcT  grantSrc
);

    arbStateT state;
    srcT      tiePtr;           // Source that wins a QoS tie
    srcT      pickSrc;
    logic     anyValid;

    // ========================================
    // Winner selection
    // ========================================
    always_comb begin
        anyValid = s00Valid | s01Valid;
        if (s00Valid && s01Valid) begin
            if (s00Qos > s01Qos) begin
                pickSrc = SRC_S00;
            end else if (s01Qos > s00Qos) begin
                pickSrc = SRC_S01;
            end else begin
                pickSrc = tiePtr;   // Same priority
            end
        end else if (s01Valid) begin
            pickSrc = SRC_S01;
        end else begin
            pickSrc = SRC_S00;
        end
    end

    // ========================================
    // Grant FSM
    // ========================================
    always_ff @(posedge ACLK) begin
        if (rst) begin
            state    <= ARB_IDLE;
            grantSrc <= SRC_S00;
            tiePtr   <= SRC_S00;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (anyValid) begin
                        state    <= ARB_BUSY;
                        grantSrc <= pickSrc;
                        // Next tie goes to the other source
                        tiePtr   <= (pickSrc == SRC_S00) ? SRC_S01 : SRC_S00;
                    end
                end
                ARB_BUSY: begin
                    if (xferDone) begin
                        state <= ARB_IDLE;  // Rearbitrate one edge later
                    end
                end
            endcase
        end
    end

    assign grantValid = (state == ARB_BUSY);

endmodule

/* src/addrDecoder.sv */
/*
 * Maps both source addresses to a write subordinate.
 * Purely combinational, both sources decoded side by side.
 */

`timescale 1ns/10ps

`include "awCtrl_consts.svh"

module addrDecoder
    import axiFieldsPkg::*;
    import awCtrlPkg::*;
(
    input  addrT s00Addr,
    input  addrT s01Addr,
    output tgtT  tgtS00,
    output tgtT  tgtS01
);

    // ========================================
    // Region check
    // ========================================
    function automatic tgtT regionOf(input addrT addr);
        tgtT tgt;
        if ((addr & addrT'(`AW_M00_MASK)) == addrT'(`AW_M00_BASE)) begin
            tgt = TGT_M00;
        end else begin
            tgt = TGT_M01;  // Default subordinate
        end
        return tgt;
    endfunction

    // Both ports looked at in the same cycle
    assign tgtS00 = regionOf(s00Addr);
    assign tgtS01 = regionOf(s01Addr);

endmodule

/* src/awChannelSwitch.sv */
/*
 * Routes the granted source to its decoded subordinate.
 * Returns awready to the granted source only and flags each handshake
 * with a one-cycle awDone and write data queue enable.
 */

`timescale 1ns/10ps

module awChannelSwitch
    import axiFieldsPkg::*;
    import awCtrlPkg::*;
(
    input  logic  ACLK,
    input  logic  rst,

    input  logic  grantValid,
    input  srcT   grantSrc,
    input  tgtT   tgtS00,
    input  tgtT   tgtS01,
    output logic  xferDone,     // Handshake this cycle

    // Source ports
    input  addrT   s00Awaddr,
    input  lenT    s00Awlen,
    input  sizeT   s00Awsize,
    input  burstT  s00Awburst,
    input  qosT    s00Awqos,
    input  logic   s00Awvalid,
    output logic   s00Awready,
    input  addrT   s01Awaddr,
    input  lenT    s01Awlen,
    input  sizeT   s01Awsize,
    input  burstT  s01Awburst,
    input  qosT    s01Awqos,
    input  logic   s01Awvalid,
    output logic   s01Awready,

    // Subordinate ports
    output srcT    m00Awid,
    output addrT   m00Awaddr,
    output lenT    m00Awlen,
    output sizeT   m00Awsize,
    output burstT  m00Awburst,
    output qosT    m00Awqos,
    output logic   m00Awvalid,
    input  logic   m00Awready,
    output srcT    m01Awid,
    output addrT   m01Awaddr,
    output lenT    m01Awlen,
    output sizeT   m01Awsize,
    output burstT  m01Awburst,
    output qosT    m01Awqos,
    output logic   m01Awvalid,
    input  logic   m01Awready,

    output qEnT    wQueueEn,
    output logic   awDone
);

    logic  fromS00;
    logic  selValid;
    logic  selReady;
    tgtT   selTgt;

    // ========================================
    // Source mux
    // ========================================
    assign fromS00  = (grantSrc == SRC_S00);
    assign selValid = grantValid & (fromS00 ? s00Awvalid : s01Awvalid);
    assign selTgt   = fromS00 ? tgtS00 : tgtS01;

    // Fields go to both subordinates, only one sees valid
    assign m00Awid    = grantSrc;
    assign m00Awaddr  = fromS00 ? s00Awaddr  : s01Awaddr;
    assign m00Awlen   = fromS00 ? s00Awlen   : s01Awlen;
    assign m00Awsize  = fromS00 ? s00Awsize  : s01Awsize;
    assign m00Awburst = fromS00 ? s00Awburst : s01Awburst;
    assign m00Awqos   = fromS00 ? s00Awqos   : s01Awqos;
    assign m01Awid    = grantSrc;
    assign m01Awaddr  = m00Awaddr;
    assign m01Awlen   = m00Awlen;
    assign m01Awsize  = m00Awsize;
    assign m01Awburst = m00Awburst;
    assign m01Awqos   = m00Awqos;

    assign m00Awvalid = selValid & (selTgt == TGT_M00);
    assign m01Awvalid = selValid & (selTgt == TGT_M01);

    // ========================================
    // Ready return and handshake
    // ========================================
    assign selReady   = (selTgt == TGT_M00) ? m00Awready : m01Awready;
    assign s00Awready = grantValid & fromS00 & selReady;
    assign s01Awready = grantValid & ~fromS00 & selReady;
    assign xferDone   = selValid & selReady;

    always_ff @(posedge ACLK) begin
        if (rst) begin
            awDone   <= 1'b0;
            wQueueEn <= '0;
        end else begin
            awDone   <= xferDone;
            // One-hot on the accepting subordinate
            wQueueEn <= xferDone ? {selTgt == TGT_M01, selTgt == TGT_M00} : '0;
        end
    end

endmodule

/* src/awChannelCtrl.sv */
/*
 * AW channel controller for a two-manager, two-subordinate AXI4 interconnect.
 * Ties the QoS arbiter, address decoder and channel switch together.
 */

`timescale 1ns/10ps

module awChannelCtrl
    import axiFieldsPkg::*;
    import awCtrlPkg::*;
(
    input  logic   ACLK,
    input  logic   rst,

    // ========================================
    // Sources
    // ========================================
    input  addrT   s00Awaddr,
    input  lenT    s00Awlen,
    input  sizeT   s00Awsize,
    input  burstT  s00Awburst,
    input  qosT    s00Awqos,
    input  logic   s00Awvalid,
    output logic   s00Awready,
    input  addrT   s01Awaddr,
    input  lenT    s01Awlen,
    input  sizeT   s01Awsize,
    input  burstT  s01Awburst,
    input  qosT    s01Awqos,
    input  logic   s01Awvalid,
    output logic   s01Awready,

    // ========================================
    // Subordinates
    // ========================================
    output srcT    m00Awid,
    output addrT   m00Awaddr,
    output lenT    m00Awlen,
    output sizeT   m00Awsize,
    output burstT  m00Awburst,
    output qosT    m00Awqos,
    output logic   m00Awvalid,
    input  logic   m00Awready,
    output srcT    m01Awid,
    output addrT   m01Awaddr,
    output lenT    m01Awlen,
    output sizeT   m01Awsize,
    output burstT  m01Awburst,
    output qosT    m01Awqos,
    output logic   m01Awvalid,
    input  logic   m01Awready,

    output qEnT    wQueueEn,    // Write data queue enables
    output logic   awDone
);

    logic grantValid;
    srcT  grantSrc;
    tgtT  tgtS00;
    tgtT  tgtS01;
    logic xferDone;

    qosArbiter qosArbiter_inst (
        .ACLK       (ACLK),
        .rst        (rst),
        .s00Valid   (s00Awvalid),
        .s00Qos     (s00Awqos),
        .s01Valid   (s01Awvalid),
        .s01Qos     (s01Awqos),
        .xferDone   (xferDone),
        .grantValid (grantValid),
        .grantSrc   (grantSrc)
    );

    addrDecoder addrDecoder_inst (
        .s00Addr (s00Awaddr),
        .s01Addr (s01Awaddr),
        .tgtS00  (tgtS00),
        .tgtS01  (tgtS01)
    );

    awChannelSwitch awChannelSwitch_inst (
        .ACLK       (ACLK),
        .rst        (rst),
        .grantValid (grantValid),
        .grantSrc   (grantSrc),
        .tgtS00     (tgtS00),
        .tgtS01     (tgtS01),
        .xferDone   (xferDone),
        .s00Awaddr  (s00Awaddr),
        .s00Awlen   (s00Awlen),
        .s00Awsize  (s00Awsize),
        .s00Awburst (s00Awburst),
        .s00Awqos   (s00Awqos),
        .s00Awvalid (s00Awvalid),
        .s00Awready (s00Awready),
        .s01Awaddr  (s01Awaddr),
        .s01Awlen   (s01Awlen),
        .s01Awsize  (s01Awsize),
        .s01Awburst (s01Awburst),
        .s01Awqos   (s01Awqos),
        .s01Awvalid (s01Awvalid),
        .s01Awready (s01Awready),
        .m00Awid    (m00Awid),
        .m00Awaddr  (m00Awaddr),
        .m00Awlen   (m00Awlen),
        .m00Awsize  (m00Awsize),
        .m00Awburst (m00Awburst),
        .m00Awqos   (m00Awqos),
        .m00Awvalid (m00Awvalid),
        .m00Awready (m00Awready),
        .m01Awid    (m01Awid),
        .m01Awaddr  (m01Awaddr),
        .m01Awlen   (m01Awlen),
        .m01Awsize  (m01Awsize),
        .m01Awburst (m01Awburst),
        .m01Awqos   (m01Awqos),
        .m01Awvalid (m01Awvalid),
        .m01Awready (m01Awready),
        .wQueueEn   (wQueueEn),
        .awDone     (awDone)
    );

endmodule

/* tb/awChannelCtrl_props.sv */
/*
 * Concurrent checks on the subordinate side of the AW channel controller.
 * Bound into awChannelCtrl alongside the testbench.
 */

`timescale 1ns/10ps

`include "awCtrl_consts.svh"

module awChannelCtrlProps
    import axiFieldsPkg::*;
    import awCtrlPkg::*;
#(
    // awid, addr, len, size, burst, qos
    parameter int PAYLOAD_W = `AW_ID_W + `AW_ADDR_W + `AW_LEN_W + `AW_SIZE_W
                              + `AW_BURST_W + `AW_QOS_W
)(
    input logic                 ACLK,
    input logic                 rst,
    input logic                 m00Awvalid,
    input logic                 m00Awready,
    input logic [PAYLOAD_W-1:0] m00Payload,
    input logic                 m01Awvalid,
    input logic                 m01Awready,
    input logic [PAYLOAD_W-1:0] m01Payload,
    input qEnT                  wQueueEn
);

    // ========================================
    // Request hold under back-pressure
    // ========================================
    m00HoldA: assert property (@(posedge ACLK) disable iff (rst)
        m00Awvalid && !m00Awready |=> m00Awvalid && $stable(m00Payload))
        else $error("M00 request dropped or changed before awready");

    m01HoldA: assert property (@(posedge ACLK) disable iff (rst)
        m01Awvalid && !m01Awready |=> m01Awvalid && $stable(m01Payload))
        else $error("M01 request dropped or changed before awready");

    // One subordinate at a time
    oneTargetA: assert property (@(posedge ACLK) disable iff (rst)
        !(m00Awvalid && m01Awvalid))
        else $error("Both subordinates see awvalid");

    queueEnA: assert property (@(posedge ACLK) disable iff (rst)
        $onehot0(wQueueEn))
        else $error("Write data queue enable has more than one bit set");

endmodule

bind awChannelCtrl awChannelCtrlProps awChannelCtrlProps_inst (
    .ACLK       (ACLK),
    .rst        (rst),
    .m00Awvalid (m00Awvalid),
    .m00Awready (m00Awready),
    .m00Payload ({m00Awid, m00Awaddr, m00Awlen, m00Awsize, m00Awburst, m00Awqos}),
    .m01Awvalid (m01Awvalid),
    .m01Awready (m01Awready),
    .m01Payload ({m01Awid, m01Awaddr, m01Awlen, m01Awsize, m01Awburst, m01Awqos}),
    .wQueueEn   (wQueueEn)
);

/* tb/awChannelCtrlTb.sv */
/*
 * Testbench for the AW channel controller.
 * Random requests from both sources meet random subordinate back-pressure.
 * Every handshake is compared with a model of the arbitration and decode rules.
 */

`timescale 1ns/10ps

`include "awCtrl_consts.svh"

module awChannelCtrlTb
    import axiFieldsPkg::*;
    import awCtrlPkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int NUM_XFERS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_XFERS * 20;
    localparam int SEED           = 32'h05e3_ae93;

    typedef struct packed {
        srcT   id;
        tgtT   tgt;
        addrT  addr;
        lenT   len;
        sizeT  size;
        burstT burst;
        qosT   qos;
    } xferT;

    logic  ACLK;
    logic  rst;
    addrT  s00Awaddr, s01Awaddr, m00Awaddr, m01Awaddr;
    lenT   s00Awlen, s01Awlen, m00Awlen, m01Awlen;
    sizeT  s00Awsize, s01Awsize, m00Awsize, m01Awsize;
    burstT s00Awburst, s01Awburst, m00Awburst, m01Awburst;
    qosT   s00Awqos, s01Awqos, m00Awqos, m01Awqos;
    logic  s00Awvalid, s01Awvalid, m00Awvalid, m01Awvalid;
    logic  s00Awready, s01Awready, m00Awready, m01Awready;
    srcT   m00Awid, m01Awid;
    qEnT   wQueueEn;
    logic  awDone;

    // Reference model state
    xferT  expQ[$];
    logic  modelBusy;
    srcT   modelSrc;
    tgtT   modelTgt;
    srcT   tiePtr;
    logic  expDone;
    qEnT   expQEn;
    logic  s00Acc, s01Acc;          // Accepted at the coming edge
    int    xferCount = 0;
    int    cycleCount = 0;
    int    errorCount = 0;

    initial ACLK = 1'b0;
    always #(CLK_PERIOD / 2) ACLK = ~ACLK;

    awChannelCtrl awChannelCtrl_inst (.*);

    always @(posedge ACLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: only %0d of %0d transfers finished", xferCount, NUM_XFERS);
            $display("SIMULATION FAILED");
            $fatal(1, "Run stopped after %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // ========================================
    // Check and model helpers
    // ========================================
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // M00 owns the region selected by base and mask
    function automatic tgtT decodeTarget(input addrT addr);
        return ((addr & `AW_M00_MASK) == `AW_M00_BASE) ? TGT_M00 : TGT_M01;
    endfunction

    function automatic xferT portFields(input tgtT t);
        xferT f;
        f.tgt   = t;
        f.id    = (t == TGT_M00) ? m00Awid    : m01Awid;
        f.addr  = (t == TGT_M00) ? m00Awaddr  : m01Awaddr;
        f.len   = (t == TGT_M00) ? m00Awlen   : m01Awlen;
        f.size  = (t == TGT_M00) ? m00Awsize  : m01Awsize;
        f.burst = (t == TGT_M00) ? m00Awburst : m01Awburst;
        f.qos   = (t == TGT_M00) ? m00Awqos   : m01Awqos;
        return f;
    endfunction

    task automatic checkIdleOutputs();
        checkValue("m00Awvalid", 32'(m00Awvalid), 32'd0);
        checkValue("m01Awvalid", 32'(m01Awvalid), 32'd0);
        checkValue("s00Awready", 32'(s00Awready), 32'd0);
        checkValue("s01Awready", 32'(s01Awready), 32'd0);
        checkValue("wQueueEn", 32'(wQueueEn), 32'd0);
        checkValue("awDone", 32'(awDone), 32'd0);
    endtask

    // Runs mid-cycle and works out what the coming edge does
    task automatic stepModel();
        logic tgtReady;
        srcT  pick;
        xferT exp;
        xferT got;
        checkValue("awDone", 32'(awDone), 32'(expDone));
        checkValue("wQueueEn", 32'(wQueueEn), 32'(expQEn));
        checkValue("m00Awvalid", 32'(m00Awvalid), 32'(modelBusy && modelTgt == TGT_M00));
        checkValue("m01Awvalid", 32'(m01Awvalid), 32'(modelBusy && modelTgt == TGT_M01));
        tgtReady = (modelTgt == TGT_M00) ? m00Awready : m01Awready;
        checkValue("s00Awready", 32'(s00Awready),
                   32'(modelBusy && modelSrc == SRC_S00 && tgtReady));
        checkValue("s01Awready", 32'(s01Awready),
                   32'(modelBusy && modelSrc == SRC_S01 && tgtReady));
        s00Acc = s00Awvalid && s00Awready;
        s01Acc = s01Awvalid && s01Awready;
        expDone = 1'b0;
        expQEn  = '0;
        if (modelBusy && tgtReady) begin
            if (expQ.size() == 0) begin
                $display("A subordinate handshake happened with no request expected");
                $display("SIMULATION FAILED");
                $fatal(1, "Unexpected handshake");
            end
            exp = expQ.pop_front();
            got = portFields(modelTgt);
            checkValue("awid", 32'(got.id), 32'(exp.id));
            checkValue("awaddr", got.addr, exp.addr);
            checkValue("awlen", 32'(got.len), 32'(exp.len));
            checkValue("awsize", 32'(got.size), 32'(exp.size));
            checkValue("awburst", 32'(got.burst), 32'(exp.burst));
            checkValue("awqos", 32'(got.qos), 32'(exp.qos));
            xferCount++;
            modelBusy = 1'b0;
            expDone   = 1'b1;
            expQEn    = (modelTgt == TGT_M00) ? 2'b01 : 2'b10;
        end else if (!modelBusy && (s00Awvalid || s01Awvalid)) begin
            if (s00Awvalid && s01Awvalid) begin
                if (s00Awqos != s01Awqos) begin
                    pick = (s00Awqos > s01Awqos) ? SRC_S00 : SRC_S01;
                end else begin
                    pick = tiePtr;
                end
            end else begin
                pick = s00Awvalid ? SRC_S00 : SRC_S01;
            end
            tiePtr    = (pick == SRC_S00) ? SRC_S01 : SRC_S00;
            exp.id    = pick;
            exp.addr  = (pick == SRC_S00) ? s00Awaddr  : s01Awaddr;
            exp.len   = (pick == SRC_S00) ? s00Awlen   : s01Awlen;
            exp.size  = (pick == SRC_S00) ? s00Awsize  : s01Awsize;
            exp.burst = (pick == SRC_S00) ? s00Awburst : s01Awburst;
            exp.qos   = (pick == SRC_S00) ? s00Awqos   : s01Awqos;
            exp.tgt   = decodeTarget(exp.addr);
            expQ.push_back(exp);
            modelBusy = 1'b1;
            modelSrc  = pick;
            modelTgt  = exp.tgt;
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================
    task automatic randomRequest(output addrT addr, output lenT len, output sizeT size,
                                 output burstT burst, output qosT qos);
        addr  = addrT'($urandom);
        len   = lenT'($urandom);
        size  = sizeT'($urandom_range(0, 7));
        burst = burstT'($urandom_range(0, 3));
        // Mostly two close levels so ties come up often
        qos   = ($urandom_range(0, 3) == 0) ? qosT'($urandom) : qosT'($urandom_range(8, 9));
    endtask

    task automatic driveInputs();
        if (s00Acc) s00Awvalid = 1'b0;
        if (s01Acc) s01Awvalid = 1'b0;
        if (!s00Awvalid && $urandom_range(0, 3) != 0) begin
            randomRequest(s00Awaddr, s00Awlen, s00Awsize, s00Awburst, s00Awqos);
            s00Awvalid = 1'b1;
        end
        if (!s01Awvalid && $urandom_range(0, 3) != 0) begin
            randomRequest(s01Awaddr, s01Awlen, s01Awsize, s01Awburst, s01Awqos);
            s01Awvalid = 1'b1;
        end
        m00Awready = ($urandom_range(0, 4) < 3);
        m01Awready = ($urandom_range(0, 4) < 3);
    endtask

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        {s00Awaddr, s00Awlen, s00Awsize, s00Awqos, s00Awvalid} = '0;
        {s01Awaddr, s01Awlen, s01Awsize, s01Awqos, s01Awvalid} = '0;
        s00Awburst = BURST_FIXED;
        s01Awburst = BURST_FIXED;
        m00Awready = 1'b0;
        m01Awready = 1'b0;
        modelBusy  = 1'b0;
        modelSrc   = SRC_S00;
        modelTgt   = TGT_M00;
        tiePtr     = SRC_S00;           // Matches the arbiter after reset
        expDone    = 1'b0;
        expQEn     = '0;
        s00Acc     = 1'b0;
        s01Acc     = 1'b0;
        repeat (2) @(posedge ACLK);
        @(negedge ACLK);
        checkIdleOutputs();
        @(posedge ACLK);
        #2 rst = 1'b0;
        while (xferCount < NUM_XFERS) begin
            @(negedge ACLK);
            stepModel();
            @(posedge ACLK);
            #2;
            driveInputs();
        end
        // Last handshake still owes its awDone and queue enable
        @(negedge ACLK);
        stepModel();
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+src
src/axiFieldsPkg.sv
src/awCtrlPkg.sv
src/qosArbiter.sv
src/addrDecoder.sv
src/awChannelSwitch.sv
src/awChannelCtrl.sv
tb/awChannelCtrl_props.sv
tb/awChannelCtrlTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the AW channel controller testbench with Verilator.
# Run from the project root. Exit status is 0 only when the run passed.

TOP=awChannelCtrlTb
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f src.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0
